//--- hdl/creditSender.sv
// Two-entry output buffer that sends one item per downstream credit, used once per output port
`timescale 1ns/100ps
`include "klLoader_macros.svh"

module creditSender #(
  parameter type payloadT = logic
) (
  input  logic    clk,
  input  logic    rstN,
  input  logic    inValid,
  input  payloadT inData,
  output logic    inReady,
  input  logic    credit,
  output logic    outValid,
  output payloadT outData
);

  localparam int maxCredits = `KL_OUT_CREDITS;
  localparam int cntW = $clog2(maxCredits + 1);

  payloadT         slots [2];
  logic            wrSel;
  logic            rdSel;
  logic [1:0]      fill;
  logic [cntW-1:0] creditCnt;
  logic            push;

  // Accept while a slot is empty
  assign inReady = (fill != 2'd2);
  assign push = inValid && inReady;

  // Send whenever an item and a credit are both there
  assign outValid = (fill != 2'd0) && (creditCnt != '0);
  assign outData = slots[rdSel];

  always_ff @(posedge clk) begin
    if (push) begin
      slots[wrSel] <= inData;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      wrSel <= 1'b0;
      rdSel <= 1'b0;
      fill <= '0;
      // Consumer starts with every slot free
      creditCnt <= cntW'(maxCredits);
    end else begin
      if (push) begin
        wrSel <= !wrSel;
      end
      if (outValid) begin
        rdSel <= !rdSel;
      end
      fill <= fill + {1'b0, push} - {1'b0, outValid};
      // Returned credit and a send may share a cycle
      creditCnt <= creditCnt + cntW'(credit) - cntW'(outValid);
    end
  end

endmodule

//--- hdl/fieldDecoder.sv
// Buffers incoming load-file characters and turns them into record, field and end-of-line tokens
`timescale 1ns/100ps
`include "klLoader_macros.svh"

module fieldDecoder (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   charValid,
  input  logic [6:0]             charData,
  output logic                   charCredit,
  output logic                   tokValid,
  output klLoaderPkg::lineTokenT tok,
  input  logic                   tokReady
);
  import klLoaderPkg::*;

  localparam int depth = `KL_CHAR_CREDITS;
  localparam int ptrW = $clog2(depth);

  // Characters with a meaning of their own
  localparam logic [6:0] chLf = 7'h0a;
  localparam logic [6:0] chCr = 7'h0d;
  localparam logic [6:0] chSpace = 7'h20;
  localparam logic [6:0] chComma = 7'h2c;

  logic [6:0]      charBuf [depth];
  logic [ptrW-1:0] wrPtr;
  logic [ptrW-1:0] rdPtr;
  logic [ptrW:0]   used;
  logic [6:0]      head;
  logic            haveChar;
  logic            slotFree;
  logic            emit;
  logic            pop;
  lineTokenT       nextTok;

  // Line position state
  logic        lineStart;
  logic        afterType;
  logic        eolPending;
  logic [15:0] acc;

  ////////////////////////////////////////////////////////////
  // Decision for the character at the head of the buffer

  always_comb begin
    head = charBuf[rdPtr];
    haveChar = (used != '0);
    slotFree = !tokValid || tokReady;
    emit = 1'b0;
    nextTok = '{kind: tokField, recChar: head, value: acc};
    if (eolPending) begin
      // Second token of a newline
      emit = 1'b1;
      nextTok.kind = tokEol;
    end else if (haveChar) begin
      if (lineStart) begin
        // Blank lines and stray CRs give no record
        emit = (head != chCr) && (head != chLf);
        nextTok.kind = tokRecType;
        nextTok.value = '0;
      end else begin
        emit = (head == chComma) || (head == chLf);
      end
    end
    // Characters that make no token never wait for the output
    pop = haveChar && !eolPending && (slotFree || !emit);
  end

  // Source guarantees space through its credits
  always_ff @(posedge clk) begin
    if (charValid) begin
      charBuf[wrPtr] <= charData;
    end
  end

  always_ff @(posedge clk) begin
    if (slotFree) begin
      tok <= nextTok;
    end
  end

  ////////////////////////////////////////////////////////////
  // Buffer pointers, credit return and line state

  always_ff @(posedge clk) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      used <= '0;
      charCredit <= 1'b0;
      tokValid <= 1'b0;
      lineStart <= 1'b1;
      afterType <= 1'b0;
      eolPending <= 1'b0;
      acc <= '0;
    end else begin
      // One credit back per character removed
      charCredit <= pop;
      if (charValid) begin
        wrPtr <= (wrPtr == ptrW'(depth - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (pop) begin
        rdPtr <= (rdPtr == ptrW'(depth - 1)) ? '0 : rdPtr + 1'b1;
      end
      used <= used + {{ptrW{1'b0}}, charValid} - {{ptrW{1'b0}}, pop};
      if (slotFree) begin
        tokValid <= emit;
      end
      if (eolPending && slotFree) begin
        eolPending <= 1'b0;
        lineStart <= 1'b1;
      end
      if (pop) begin
        if (lineStart) begin
          if (emit) begin
            lineStart <= 1'b0;
            afterType <= 1'b1;
          end
        end else if (afterType && (head == chSpace)) begin
          // Separator after the record letter
          afterType <= 1'b0;
        end else begin
          afterType <= 1'b0;
          if (head == chComma) begin
            acc <= '0;
          end else if (head == chLf) begin
            acc <= '0;
            eolPending <= 1'b1;
          end else if (head != chCr) begin
            // Six bits per character, older bits fall off the top
            acc <= {acc[9:0], head[5:0]};
          end
        end
      end
    end
  end

endmodule

//--- hdl/klLoaderPkg.sv
// Types passed between the loader stages and out of the loader, imported by each stage
`include "klLoader_macros.svh"

package klLoaderPkg;

  ////////////////////////////////////////////////////////////
  // Token stream from the character decoder

  // What a token means to the record parser
  typedef enum logic [1:0] {
    tokRecType,
    tokField,
    tokEol
  } tokenKindT;

  // Record character is only meaningful for tokRecType
  // Value holds the decoded 16-bit field
  typedef struct packed {
    tokenKindT   kind;
    logic [6:0]  recChar;
    logic [15:0] value;
  } lineTokenT;

  ////////////////////////////////////////////////////////////
  // Data words from the record parser

  typedef enum logic {
    ramCram,
    ramDram
  } ramKindT;

  // Dispatch words use only the low address bits
  // Pos counts the word within its location group
  typedef struct packed {
    ramKindT                   ram;
    logic [`KL_CRAM_ADR_W-1:0] adr;
    logic [2:0]                pos;
    logic [15:0]               value;
  } dataWordT;

  ////////////////////////////////////////////////////////////
  // Write transactions leaving the loader

  typedef struct packed {
    logic [`KL_CRAM_ADR_W-1:0] adr;
    logic [`KL_CRAM_W-1:0]     data;
  } cramWriteT;

  // One dispatch location
  // J holds J1-J4, two zero bits for J5-J6, then J7-J10
  typedef struct packed {
    logic [2:0] a;
    logic [2:0] b;
    logic       parity;
    logic [9:0] j;
  } dramEntryT;

  // Even and odd locations written together
  typedef struct packed {
    logic [`KL_DRAM_ADR_W-1:0] adr;
    dramEntryT                 even;
    dramEntryT                 odd;
  } dramPairT;

endpackage

//--- hdl/klLoader_macros.svh
// Widths, word counts and credit counts shared by the loader RTL, included where needed
`ifndef KL_LOADER_MACROS_SVH
`define KL_LOADER_MACROS_SVH

// Character buffer depth
// The source starts with this many credits
`define KL_CHAR_CREDITS 4

// Consumer slots per output port after reset
`define KL_OUT_CREDITS 2

// Control RAM address and word widths
`define KL_CRAM_ADR_W 11
`define KL_CRAM_W 86

// Dispatch RAM address width
// Writes always go to an even address
`define KL_DRAM_ADR_W 9

// File words per control RAM location
`define KL_CRAM_WORDS 6

// File words per dispatch RAM pair (even, odd, common)
`define KL_DRAM_WORDS 3

`endif

//--- hdl/microcodeLoader.sv
// Top level of the microcode loader, wiring decoder, parser, assembler and the two output senders
`timescale 1ns/100ps

module microcodeLoader (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   charValid,
  input  logic [6:0]             charData,
  output logic                   charCredit,
  input  logic                   cramCredit,
  input  logic                   dramCredit,
  output logic                   cramValid,
  output klLoaderPkg::cramWriteT cramWrite,
  output logic                   dramValid,
  output klLoaderPkg::dramPairT  dramWrite,
  output logic [7:0]             badLines,
  output logic                   loadDone
);
  import klLoaderPkg::*;

  // Decoder to parser
  logic      tokValid;
  logic      tokReady;
  lineTokenT tok;

  // Parser to assembler
  logic     wordValid;
  logic     wordReady;
  dataWordT word;

  // Assembler to senders
  logic      cramOutValid;
  logic      cramOutReady;
  cramWriteT cramOut;
  logic      dramOutValid;
  logic      dramOutReady;
  dramPairT  dramOut;

  fieldDecoder fieldDecoder_i (
    .clk        (clk),
    .rstN       (rstN),
    .charValid  (charValid),
    .charData   (charData),
    .charCredit (charCredit),
    .tokValid   (tokValid),
    .tok        (tok),
    .tokReady   (tokReady)
  );

  recordParser recordParser_i (
    .clk       (clk),
    .rstN      (rstN),
    .tokValid  (tokValid),
    .tok       (tok),
    .tokReady  (tokReady),
    .wordValid (wordValid),
    .word      (word),
    .wordReady (wordReady),
    .badLines  (badLines),
    .loadDone  (loadDone)
  );

  ramWordAssembler ramWordAssembler_i (
    .clk          (clk),
    .rstN         (rstN),
    .wordValid    (wordValid),
    .word         (word),
    .wordReady    (wordReady),
    .cramOutValid (cramOutValid),
    .cramOut      (cramOut),
    .cramOutReady (cramOutReady),
    .dramOutValid (dramOutValid),
    .dramOut      (dramOut),
    .dramOutReady (dramOutReady)
  );

  ////////////////////////////////////////////////////////////
  // Output ports

  creditSender #(.payloadT(cramWriteT)) cramSender_i (
    .clk      (clk),
    .rstN     (rstN),
    .inValid  (cramOutValid),
    .inData   (cramOut),
    .inReady  (cramOutReady),
    .credit   (cramCredit),
    .outValid (cramValid),
    .outData  (cramWrite)
  );

  creditSender #(.payloadT(dramPairT)) dramSender_i (
    .clk      (clk),
    .rstN     (rstN),
    .inValid  (dramOutValid),
    .inData   (dramOut),
    .inReady  (dramOutReady),
    .credit   (dramCredit),
    .outValid (dramValid),
    .outData  (dramWrite)
  );

endmodule

//--- hdl/ramWordAssembler.sv
// Collects data words into control RAM locations and dispatch RAM pairs for the output senders
`timescale 1ns/100ps
`include "klLoader_macros.svh"

module ramWordAssembler (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic                  wordValid,
  input  klLoaderPkg::dataWordT word,
  output logic                  wordReady,
  output logic                  cramOutValid,
  output klLoaderPkg::cramWriteT cramOut,
  input  logic                  cramOutReady,
  output logic                  dramOutValid,
  output klLoaderPkg::dramPairT dramOut,
  input  logic                  dramOutReady
);
  import klLoaderPkg::*;

  localparam int cramLast = `KL_CRAM_WORDS - 1;
  localparam int dramLast = `KL_DRAM_WORDS - 1;
  localparam int dAdrW = `KL_DRAM_ADR_W;
  // Bits 0-79 come from five full words
  localparam int bodyW = `KL_CRAM_W - 6;

  logic [bodyW-1:0] cramBuild;
  logic [15:0]      evenWord;
  logic [15:0]      oddWord;
  logic             isCram;
  logic             lastPos;
  logic             outFree;
  logic             take;

  // Spread one dispatch word over the entry fields
  // Common word supplies J1-J4
  function automatic dramEntryT mkEntry(logic [15:0] own, logic [15:0] common);
    dramEntryT e;
    e.a = own[13:11];
    e.b = own[10:8];
    e.parity = own[5];
    e.j = {common[3:0], 2'b00, own[3:0]};
    return e;
  endfunction

  ////////////////////////////////////////////////////////////
  // Flow control

  always_comb begin
    isCram = (word.ram == ramCram);
    lastPos = isCram ? (word.pos == 3'(cramLast)) : (word.pos == 3'(dramLast));
    outFree = isCram ? (!cramOutValid || cramOutReady) : (!dramOutValid || dramOutReady);
    // Only the word that completes an item needs the output
    wordReady = !lastPos || outFree;
    take = wordValid && wordReady;
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      cramOutValid <= 1'b0;
      dramOutValid <= 1'b0;
    end else begin
      if (cramOutReady) begin
        cramOutValid <= 1'b0;
      end
      if (dramOutReady) begin
        dramOutValid <= 1'b0;
      end
      if (take && lastPos) begin
        if (isCram) begin
          cramOutValid <= 1'b1;
        end else begin
          dramOutValid <= 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Slice placement

  always_ff @(posedge clk) begin
    if (take && isCram) begin
      case (word.pos)
        3'd0: cramBuild[79:64] <= word.value;
        3'd1: cramBuild[63:48] <= word.value;
        3'd2: cramBuild[47:32] <= word.value;
        3'd3: cramBuild[31:16] <= word.value;
        3'd4: cramBuild[15:0] <= word.value;
        default: begin
          // Last word carries only the six special bits 80-85
          cramOut.adr <= word.adr;
          cramOut.data <= {word.value[5:0], cramBuild};
        end
      endcase
    end
    if (take && !isCram) begin
      case (word.pos)
        3'd0: evenWord <= word.value;
        3'd1: oddWord <= word.value;
        default: begin
          // Pairs always start on an even location
          dramOut.adr <= {word.adr[dAdrW-1:1], 1'b0};
          dramOut.even <= mkEntry(evenWord, word.value);
          dramOut.odd <= mkEntry(oddWord, word.value);
        end
      endcase
    end
  end

endmodule

//--- hdl/recordParser.sv
// Parses token lines into RAM data words and keeps checksum, last-address and done state
`timescale 1ns/100ps
`include "klLoader_macros.svh"

module recordParser (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   tokValid,
  input  klLoaderPkg::lineTokenT tok,
  output logic                   tokReady,
  output logic                   wordValid,
  output klLoaderPkg::dataWordT  word,
  input  logic                   wordReady,
  output logic [7:0]             badLines,
  output logic                   loadDone
);
  import klLoaderPkg::*;

  localparam int adrW = `KL_CRAM_ADR_W;
  localparam int dAdrW = `KL_DRAM_ADR_W;

  // Record letters
  localparam logic [6:0] typeC = 7'h43;
  localparam logic [6:0] typeD = 7'h44;
  localparam logic [6:0] typeZ = 7'h5a;
  localparam logic [6:0] typeNote = 7'h3b;

  logic             take;
  logic [6:0]       recType;
  logic [16:0]      fieldIdx;
  logic [15:0]      wc;
  logic [16:0]      dataEnd;
  logic [15:0]      sum;
  logic [2:0]       pos;
  logic [adrW-1:0]  curAdr;
  logic [adrW-1:0]  lastCram;
  logic [dAdrW-1:0] lastDram;
  logic             isCram;
  logic             isDram;
  logic             isData;
  logic             groupEnd;
  logic             emitWord;
  logic             sumBad;
  logic [adrW-1:0]  startAdr;
  logic [adrW-1:0]  stepAdr;

  ////////////////////////////////////////////////////////////
  // Field classification

  always_comb begin
    // Tokens wait only for a free word slot
    tokReady = !wordValid || wordReady;
    take = tokValid && tokReady;
    isCram = (recType == typeC);
    isDram = (recType == typeD);
    // Field 0 is WC and field 1 is ADR
    // Data follows, then the checksum at dataEnd
    dataEnd = {1'b0, wc} + 17'd2;
    isData = (fieldIdx >= 17'd2) && (fieldIdx < dataEnd);
    groupEnd = isDram ? (pos == 3'(`KL_DRAM_WORDS - 1)) : (pos == 3'(`KL_CRAM_WORDS - 1));
    emitWord = take && (tok.kind == tokField) && isData && (isCram || isDram);
    // Zero ADR continues where the last line of that RAM stopped
    if (tok.value == '0) begin
      startAdr = isDram ? adrW'(lastDram) : lastCram;
    end else begin
      startAdr = isDram ? adrW'(tok.value[dAdrW-1:0]) : tok.value[adrW-1:0];
    end
    // One control location or one dispatch pair per group
    stepAdr = isDram ? curAdr + adrW'(2) : curAdr + adrW'(1);
    // Unknown types count as bad whatever their sum
    sumBad = (isCram || isDram || (recType == typeZ)) ? (sum != '0) : 1'b1;
  end

  always_ff @(posedge clk) begin
    if (emitWord) begin
      word <= '{ram: isDram ? ramDram : ramCram, adr: curAdr, pos: pos, value: tok.value};
    end
  end

  ////////////////////////////////////////////////////////////
  // Line state, addresses and status

  always_ff @(posedge clk) begin
    if (!rstN) begin
      wordValid <= 1'b0;
      badLines <= '0;
      loadDone <= 1'b0;
      recType <= typeNote;
      fieldIdx <= '0;
      wc <= '0;
      sum <= '0;
      pos <= '0;
      curAdr <= '0;
      lastCram <= '0;
      lastDram <= '0;
    end else begin
      if (wordReady) begin
        wordValid <= 1'b0;
      end
      if (emitWord) begin
        wordValid <= 1'b1;
        if (groupEnd) begin
          pos <= '0;
          curAdr <= stepAdr;
          if (isDram) begin
            lastDram <= stepAdr[dAdrW-1:0];
          end else begin
            lastCram <= stepAdr;
          end
        end else begin
          pos <= pos + 3'd1;
        end
      end
      if (take) begin
        case (tok.kind)
          tokRecType: begin
            recType <= tok.recChar;
            fieldIdx <= '0;
            wc <= '0;
            sum <= '0;
            pos <= '0;
          end
          tokField: begin
            fieldIdx <= fieldIdx + 17'd1;
            // Fields past the checksum stay out of the sum
            if (fieldIdx <= dataEnd) begin
              sum <= sum + tok.value;
            end
            if (fieldIdx == 17'd0) begin
              wc <= tok.value;
            end
            if (fieldIdx == 17'd1) begin
              curAdr <= startAdr;
            end
          end
          tokEol: begin
            if ((recType != typeNote) && sumBad && (badLines != 8'hff)) begin
              badLines <= badLines + 8'd1;
            end
            // D end marker
            if (isDram && (wc == '0)) begin
              loadDone <= 1'b1;
            end
            // Anything before the next record letter is ignored
            recType <= typeNote;
          end
          default: begin
          end
        endcase
      end
    end
  end

endmodule

//--- sources.f
+incdir+hdl
hdl/klLoaderPkg.sv
hdl/fieldDecoder.sv
hdl/recordParser.sv
hdl/ramWordAssembler.sv
hdl/creditSender.sv
hdl/microcodeLoader.sv
testbench/microcodeLoader_assertions.sv
testbench/microcodeLoaderTb.sv

//--- testbench/microcodeLoaderTb.sv
// Self-checking testbench for the microcode loader, top module of the simulation built from sources.f
`timescale 1ns/100ps
`include "klLoader_macros.svh"

module microcodeLoaderTb;
  import klLoaderPkg::*;

  // Record letters
  localparam logic [6:0] recC = 7'h43;
  localparam logic [6:0] recD = 7'h44;
  localparam logic [6:0] recZ = 7'h5a;

  // DUT ports
  logic       clk;
  logic       rstN;
  logic       charValid;
  logic [6:0] charData;
  logic       charCredit;
  logic       cramCredit;
  logic       dramCredit;
  logic       cramValid;
  cramWriteT  cramWrite;
  logic       dramValid;
  dramPairT   dramWrite;
  logic [7:0] badLines;
  logic       loadDone;

  // Generated load file and the model's expected writes
  logic [6:0]  chars [$];
  logic [15:0] lineFields [$];
  cramWriteT   cramExp [$];
  dramPairT    dramExp [$];
  logic [10:0] cramLast;
  logic [8:0]  dramLast;
  logic [31:0] rngState;
  bit          genDone;

  // Source and consumer bookkeeping
  int sentIdx;
  int srcCredits;
  int creditsBack;
  int cycle;
  int cramFree;
  int dramFree;
  int cramDue [$];
  int dramDue [$];

  microcodeLoader dut_i (
    .clk        (clk),
    .rstN       (rstN),
    .charValid  (charValid),
    .charData   (charData),
    .charCredit (charCredit),
    .cramCredit (cramCredit),
    .dramCredit (dramCredit),
    .cramValid  (cramValid),
    .cramWrite  (cramWrite),
    .dramValid  (dramValid),
    .dramWrite  (dramWrite),
    .badLines   (badLines),
    .loadDone   (loadDone)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Random numbers and failure handling

  function automatic logic [31:0] xorshift(logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Uniform-ish value in 0 .. n-1
  function automatic int randBelow(int n);
    rngState = xorshift(rngState);
    return int'(rngState % n);
  endfunction

  task automatic abortRun();
    $display("test failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // Failures counted by the bound credit checkers
  function automatic int boundFailures();
    return dut_i.cramSender_i.creditChecks_i.errCount +
           dut_i.dramSender_i.creditChecks_i.errCount;
  endfunction

  // Dispatch entry as the file format defines it
  // Common word gives J1-J4, J5-J6 are zero
  function automatic dramEntryT expectedEntry(logic [15:0] own, logic [15:0] common);
    return dramEntryT'({own[13:11], own[10:8], own[5], common[3:0], 2'b00, own[3:0]});
  endfunction

  ////////////////////////////////////////////////////////////
  // Load file writer

  // Six bits per character
  task automatic putGroup(logic [5:0] g);
    if (g < 6'o75) begin
      chars.push_back({1'b1, g});
    end else begin
      chars.push_back({1'b0, g});
    end
  endtask

  // Leading zero groups are dropped, zero gives an empty field
  task automatic putValue(logic [15:0] v);
    if (v >= 16'h1000) begin
      putGroup({2'b00, v[15:12]});
    end
    if (v >= 16'h0040) begin
      putGroup(v[11:6]);
    end
    if (v != 16'h0) begin
      putGroup(v[5:0]);
    end
  endtask

  // Writes the fields in lineFields and appends the checksum
  task automatic putLine(logic [6:0] rec, bit corrupt);
    logic [15:0] sum;
    logic [15:0] cks;
    int          i;
    sum = 16'h0;
    for (i = 0; i < lineFields.size(); i++) begin
      sum = sum + lineFields[i];
    end
    cks = 16'h0 - sum;
    if (corrupt) begin
      cks = cks + 16'h0101;
    end
    chars.push_back(rec);
    chars.push_back(7'h20);
    for (i = 0; i < lineFields.size(); i++) begin
      if (i > 0) begin
        chars.push_back(7'h2c);
      end
      putValue(lineFields[i]);
    end
    chars.push_back(7'h2c);
    putValue(cks);
    // CR then LF
    chars.push_back(7'h0d);
    chars.push_back(7'h0a);
  endtask

  task automatic putComment();
    int len;
    int i;
    len = 4 + randBelow(16);
    chars.push_back(7'h3b);
    chars.push_back(7'h20);
    for (i = 0; i < len; i++) begin
      if (randBelow(6) == 0) begin
        chars.push_back(7'h20);
      end else begin
        chars.push_back(7'(7'h61 + randBelow(26)));
      end
    end
    chars.push_back(7'h0d);
    chars.push_back(7'h0a);
  endtask

  // Zero-range record, only its checksum matters
  task automatic genZLine();
    int n;
    int i;
    n = 1 + randBelow(3);
    lineFields.delete();
    lineFields.push_back(16'(n));
    lineFields.push_back(16'(1 + randBelow(2047)));
    for (i = 0; i < n; i++) begin
      lineFields.push_back(16'(randBelow(65536)));
    end
    putLine(recZ, 1'b0);
  endtask

  task automatic genCramLine(bit corrupt);
    int          n;
    int          i;
    int          k;
    bit          explicitAdr;
    logic [10:0] start;
    logic [15:0] w [6];
    cramWriteT   e;
    n = 1 + randBelow(5);
    explicitAdr = (randBelow(2) == 1);
    // Zero ADR continues after the previous C line
    start = explicitAdr ? 11'(1 + randBelow(2047)) : cramLast;
    lineFields.delete();
    lineFields.push_back(16'(6 * n));
    lineFields.push_back(explicitAdr ? {5'b0, start} : 16'h0);
    for (i = 0; i < n; i++) begin
      for (k = 0; k < 6; k++) begin
        w[k] = 16'(randBelow(65536));
        lineFields.push_back(w[k]);
      end
      e.adr = start + 11'(i);
      // Word 5 supplies bits 80-85 only
      e.data = {w[5][5:0], w[0], w[1], w[2], w[3], w[4]};
      cramExp.push_back(e);
    end
    cramLast = start + 11'(n);
    putLine(recC, corrupt);
  endtask

  task automatic genDramLine();
    int          n;
    int          i;
    bit          explicitAdr;
    logic [8:0]  start;
    logic [15:0] ev;
    logic [15:0] od;
    logic [15:0] cm;
    dramPairT    e;
    n = 1 + randBelow(10);
    explicitAdr = (randBelow(2) == 1);
    // Explicit dispatch addresses are even and nonzero
    start = explicitAdr ? 9'(2 * (1 + randBelow(255))) : dramLast;
    lineFields.delete();
    lineFields.push_back(16'(3 * n));
    lineFields.push_back(explicitAdr ? {7'b0, start} : 16'h0);
    for (i = 0; i < n; i++) begin
      ev = 16'(randBelow(65536));
      od = 16'(randBelow(65536));
      cm = 16'(randBelow(65536));
      lineFields.push_back(ev);
      lineFields.push_back(od);
      lineFields.push_back(cm);
      e.adr = start + 9'(2 * i);
      e.even = expectedEntry(ev, cm);
      e.odd = expectedEntry(od, cm);
      dramExp.push_back(e);
    end
    dramLast = start + 9'(2 * n);
    putLine(recD, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////
  // Character source, one character per credit held

  always @(posedge clk) begin
    if (rstN && genDone && (srcCredits > 0) && (sentIdx < chars.size())) begin
      charValid <= 1'b1;
      charData <= chars[sentIdx];
      sentIdx++;
      srcCredits--;
    end else begin
      charValid <= 1'b0;
    end
  end

  // Consumer hands back one credit per port per cycle at most
  always @(posedge clk) begin
    cycle++;
    if ((cramDue.size() > 0) && (cramDue[0] <= cycle)) begin
      cramCredit <= 1'b1;
      cramFree++;
      void'(cramDue.pop_front());
    end else begin
      cramCredit <= 1'b0;
    end
    if ((dramDue.size() > 0) && (dramDue[0] <= cycle)) begin
      dramCredit <= 1'b1;
      dramFree++;
      void'(dramDue.pop_front());
    end else begin
      dramCredit <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Output monitor, sampled mid-cycle

  always @(negedge clk) begin
    cramWriteT expC;
    dramPairT  expD;
    assert (boundFailures() == 0) else begin
      $display("A credit assertion in an output sender failed");
      abortRun();
    end
    if (rstN) begin
      if (charCredit) begin
        creditsBack++;
        srcCredits++;
      end
      if (cramValid) begin
        assert (cramExp.size() > 0) else begin
          $display("Control RAM write arrived after the model ran out of writes");
          abortRun();
        end
        assert (cramFree > 0) else begin
          $display("Control RAM write arrived while the consumer had no free slot");
          abortRun();
        end
        expC = cramExp.pop_front();
        assert (cramWrite.adr == expC.adr) else begin
          $display("** Error: cramWrite.adr expected %h actual %h", expC.adr, cramWrite.adr);
          abortRun();
        end
        assert (cramWrite.data == expC.data) else begin
          $display("** Error: cramWrite.data expected %h actual %h", expC.data, cramWrite.data);
          abortRun();
        end
        cramFree--;
        // Retire after a random delay
        cramDue.push_back(cycle + 1 + randBelow(8));
      end
      if (dramValid) begin
        assert (dramExp.size() > 0) else begin
          $display("Dispatch RAM write arrived after the model ran out of writes");
          abortRun();
        end
        assert (dramFree > 0) else begin
          $display("Dispatch RAM write arrived while the consumer had no free slot");
          abortRun();
        end
        expD = dramExp.pop_front();
        assert (dramWrite.adr == expD.adr) else begin
          $display("** Error: dramWrite.adr expected %h actual %h", expD.adr, dramWrite.adr);
          abortRun();
        end
        assert (dramWrite.even == expD.even) else begin
          $display("** Error: dramWrite.even expected %h actual %h", expD.even, dramWrite.even);
          abortRun();
        end
        assert (dramWrite.odd == expD.odd) else begin
          $display("** Error: dramWrite.odd expected %h actual %h", expD.odd, dramWrite.odd);
          abortRun();
        end
        dramFree--;
        dramDue.push_back(cycle + 1 + randBelow(8));
      end
    end
  end

  // Generous bound of 40 cycles per character
  initial begin
    wait (genDone);
    #(chars.size() * 40 * 100);
    $display("Timeout, the load did not finish within %0d cycles", chars.size() * 40);
    abortRun();
  end

  ////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    int nC;
    int nD;
    int badIdx;
    int cDone;
    int dDone;
    rstN = 1'b0;
    charValid = 1'b0;
    charData = 7'h0;
    cramCredit = 1'b0;
    dramCredit = 1'b0;
    rngState = 32'h8a6;
    genDone = 1'b0;
    cramLast = '0;
    dramLast = '0;
    sentIdx = 0;
    srcCredits = `KL_CHAR_CREDITS;
    creditsBack = 0;
    cycle = 0;
    cramFree = `KL_OUT_CREDITS;
    dramFree = `KL_OUT_CREDITS;

    // Comments and a Z line, then C and D lines in random order
    nC = 4 + randBelow(3);
    nD = 3 + randBelow(3);
    badIdx = randBelow(nC);
    putComment();
    putComment();
    genZLine();
    cDone = 0;
    dDone = 0;
    while ((cDone < nC) || (dDone < nD)) begin
      if (randBelow(4) == 0) begin
        putComment();
      end
      if ((dDone == nD) || ((cDone < nC) && (randBelow(2) == 0))) begin
        genCramLine(cDone == badIdx);
        cDone++;
      end else begin
        genDramLine();
        dDone++;
      end
    end
    // End markers, C first and D last
    lineFields.delete();
    lineFields.push_back(16'h0);
    lineFields.push_back(16'h0);
    putLine(recC, 1'b0);
    putLine(recD, 1'b0);
    genDone = 1'b1;

    repeat (5) @(posedge clk);
    rstN <= 1'b1;

    // Wait for the whole file and every expected write
    while (!((sentIdx == chars.size()) && (creditsBack == chars.size()) &&
             (cramExp.size() == 0) && (dramExp.size() == 0))) begin
      @(negedge clk);
    end
    // Quiet period shows up any extra write
    repeat (20) @(negedge clk);

    assert (boundFailures() == 0) else begin
      $display("A credit assertion in an output sender failed");
      abortRun();
    end
    assert (badLines == 8'd1) else begin
      $display("** Error: badLines expected %h actual %h", 8'd1, badLines);
      abortRun();
    end
    assert (loadDone == 1'b1) else begin
      $display("** Error: loadDone expected %h actual %h", 1'b1, loadDone);
      abortRun();
    end
    assert (creditsBack == chars.size()) else begin
      $display("** Error: charCredit count expected %h actual %h", chars.size(), creditsBack);
      abortRun();
    end
    $display("test passed");
    $finish;
  end

endmodule

//--- testbench/microcodeLoader_assertions.sv
// Concurrent checks on the credit counter of each output sender, bound into every creditSender
`timescale 1ns/100ps
`include "klLoader_macros.svh"

module microcodeLoader_assertions (
  input logic       clk,
  input logic       rstN,
  input logic       credit,
  input logic       outValid,
  input logic [7:0] creditCnt
);

  // Failures seen so far, read by the testbench
  int errCount = 0;

  // Consumer slots counted from the port handshake alone
  logic [7:0] slotsFree;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      slotsFree <= 8'(`KL_OUT_CREDITS);
    end else begin
      slotsFree <= slotsFree + 8'(credit) - 8'(outValid);
    end
  end

  ////////////////////////////////////////////////////////////
  // Credit accounting

  // A send always spends a slot the consumer has free
  sendNeedsCredit: assert property (@(posedge clk) disable iff (!rstN)
    outValid |-> (slotsFree != 8'd0))
    else begin
      $error("Sender presented a write while the consumer had no free slot");
      errCount++;
    end

  // Consumer never hands back more slots than it has
  creditBounded: assert property (@(posedge clk) disable iff (!rstN)
    creditCnt <= 8'(`KL_OUT_CREDITS))
    else begin
      $error("Sender credit count rose above the consumer slot count");
      errCount++;
    end

  // Nothing leaves straight out of reset
  quietAfterReset: assert property (@(posedge clk)
    !rstN |=> !outValid)
    else begin
      $error("Sender presented a write in the cycle after reset");
      errCount++;
    end

endmodule

// One checker per sender instance
bind creditSender microcodeLoader_assertions creditChecks_i (
  .clk       (clk),
  .rstN      (rstN),
  .credit    (credit),
  .outValid  (outValid),
  .creditCnt (8'(creditCnt))
);
